// File: sdram_mux.f
source/sdram_mux_pkg.sv
source/slot_front.sv
source/slot_arbiter.sv
source/sdram_issue.sv
source/sdram_mux.sv
verif/tb_clock.sv
verif/sdram_model.sv
verif/sdram_mux_tb.sv

// File: verif/sdram_mux_tb.sv
// Testbench for the SDRAM slot multiplexer: four client ports against a shadow of memory
`timescale 1ns/1ns

module sdram_mux_tb import sdram_mux_pkg::*; ();

    localparam logic [SDRAM_AW-1:0] ROM_OFFSET  = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET  = 22'h3A_8000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET = 22'h3B_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET  = 22'h0A_8000;

    localparam int WIN = 1024;  // Words used per port
    // RAM from RAM_WIN and VRAM from zero land on the same words
    localparam logic [SDRAM_AW-1:0] SHADOW_BASE = VRAM_OFFSET;
    localparam logic [16:0]         RAM_WIN     = 17'(VRAM_OFFSET - RAM_OFFSET);

    localparam int N_ROM    = 32;
    localparam int N_GFX    = 32;
    localparam int N_RAM    = 24;
    localparam int N_CONC   = 20;
    localparam int N_ACCESS = N_ROM + N_GFX + 3 * N_RAM + 3 + 5 * N_CONC + 4;

    logic clk;
    logic rst_n;
    logic vblank;
    logic downloading;
    logic loop_rst;
    logic rom_cs;
    logic [18:0] rom_addr;
    logic [15:0] rom_data;
    logic rom_ok;
    logic ram_cs;
    logic [16:0] ram_addr;
    logic ram_rnw;
    logic [15:0] ram_din;
    logic [1:0] ram_wrmask;
    logic [15:0] ram_data;
    logic ram_ok;
    logic vram_cs;
    logic [17:0] vram_addr;
    logic [15:0] vram_data;
    logic vram_ok;
    logic gfx_cs;
    logic [19:0] gfx_addr;
    sdram_word_u gfx_data;
    logic gfx_ok;
    logic sdram_req;
    logic sdram_ack;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic sdram_rnw;
    logic [1:0] sdram_wrmask;
    logic [15:0] data_write;
    logic data_rdy;
    sdram_word_u data_read;
    logic refresh_en;

    logic [15:0]         shadow [WIN];  // Expected contents of the writable window
    int                  req_count;
    logic                req_last;
    logic [SDRAM_AW-1:0] addr_last;
    logic                conc_done;

    tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

    sdram_mux #(
        .ROM_OFFSET(ROM_OFFSET), .RAM_OFFSET(RAM_OFFSET),
        .VRAM_OFFSET(VRAM_OFFSET), .GFX_OFFSET(GFX_OFFSET)
    ) DUT (.*);

    sdram_model u_model (.*);

    // Hash of the full word address
    function automatic logic [15:0] mem_word(input logic [SDRAM_AW-1:0] a);
        logic [31:0] h;
        h = {10'd0, a} * 32'h9E37_79B1;
        h = h ^ (h >> 13);
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] din,
                                                input logic [1:0] mask);
        return {mask[1] ? old[15:8] : din[15:8], mask[0] ? old[7:0] : din[7:0]};
    endfunction

    // Expected word at an absolute address
    function automatic logic [15:0] ref_half(input logic [SDRAM_AW-1:0] a);
        if (a >= SHADOW_BASE && a < SHADOW_BASE + WIN) begin
            return shadow[a - SHADOW_BASE];
        end
        return mem_word(a);
    endfunction

    function automatic sdram_word_u ref_word(input logic [SDRAM_AW-1:0] a);
        sdram_word_u w;
        w.half.lo = ref_half(a);
        w.half.hi = ref_half(a + 1'b1);
        return w;
    endfunction

    function automatic logic [SDRAM_AW-1:0] port_base(input slot_id_t s);
        case (s)
            SLOT_ROM:  return ROM_OFFSET;
            SLOT_RAM:  return RAM_OFFSET;
            SLOT_VRAM: return VRAM_OFFSET;
            default:   return GFX_OFFSET;
        endcase
    endfunction

    function automatic logic port_ok(input slot_id_t s);
        case (s)
            SLOT_ROM:  return rom_ok;
            SLOT_RAM:  return ram_ok;
            SLOT_VRAM: return vram_ok;
            default:   return gfx_ok;
        endcase
    endfunction

    function automatic sdram_word_u port_data(input slot_id_t s);
        sdram_word_u w;
        w = '0;
        case (s)
            SLOT_ROM:  w.half.lo = rom_data;
            SLOT_RAM:  w.half.lo = ram_data;
            SLOT_VRAM: w.half.lo = vram_data;
            default:   w = gfx_data;
        endcase
        return w;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_half(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s returned %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_word(input string what, input sdram_word_u got, input sdram_word_u exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s returned %h, expected %h",
                                $time, what, got.word, exp.word));
        end
    endtask

    task automatic drive_port(input slot_id_t s, input logic cs, input logic [19:0] a,
                              input logic rnw, input logic [15:0] din, input logic [1:0] mask);
        case (s)
            SLOT_ROM: begin
                rom_cs   = cs;
                rom_addr = a[18:0];
            end
            SLOT_RAM: begin
                ram_cs     = cs;
                ram_addr   = a[16:0];
                ram_rnw    = rnw;
                ram_din    = din;
                ram_wrmask = mask;
            end
            SLOT_VRAM: begin
                vram_cs   = cs;
                vram_addr = a[17:0];
            end
            default: begin
                gfx_cs   = cs;
                gfx_addr = a;
            end
        endcase
    endtask

    // cs and addr held until ok, released on the edge that sees it
    task automatic port_access(input slot_id_t s, input logic [19:0] a, input logic rnw,
                               input logic [15:0] din, input logic [1:0] mask,
                               output sdram_word_u rd);
        @(negedge clk);
        drive_port(s, 1'b1, a, rnw, din, mask);
        do @(negedge clk); while (!port_ok(s));
        rd = port_data(s);
        drive_port(s, 1'b0, a, 1'b1, 16'h0000, 2'b11);
    endtask

    task automatic read_check(input slot_id_t s, input logic [19:0] a);
        sdram_word_u         got;
        logic [SDRAM_AW-1:0] abs_addr;
        port_access(s, a, 1'b1, 16'h0000, 2'b11, got);
        abs_addr = port_base(s) + SDRAM_AW'(a);
        if (s == SLOT_GFX)
            check_word($sformatf("gfx read %h", a), got, ref_word(abs_addr));
        else
            check_half($sformatf("port %0d read %h", s, a), got.half.lo, ref_half(abs_addr));
    endtask

    // Write a random word and mask at a window index, then read it back
    task automatic ram_round(input int idx);
        sdram_word_u unused;
        logic [15:0] din;
        logic [1:0]  mask;
        din  = 16'($urandom);
        mask = 2'($urandom_range(3, 0));
        port_access(SLOT_RAM, 20'(RAM_WIN + idx), 1'b0, din, mask, unused);
        shadow[idx] = merge_bytes(shadow[idx], din, mask);
        read_check(SLOT_RAM, 20'(RAM_WIN + idx));
    endtask

    task automatic read_traffic(input slot_id_t s, input int n, input int lo, input int hi);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom_range(5, 0)) @(negedge clk);
            read_check(s, 20'($urandom_range(hi, lo)));
        end
    endtask

    task automatic ram_traffic(input int n, input int lo, input int hi);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom_range(5, 0)) @(negedge clk);
            ram_round($urandom_range(hi, lo));
        end
    endtask

    task automatic pulse_loop_rst();
        @(negedge clk);
        loop_rst = 1'b1;
        @(negedge clk);
        loop_rst = 1'b0;
    endtask

    // Counts controller requests and watches the address while req waits
    always @(negedge clk) begin
        if (rst_n && sdram_req && req_last && sdram_addr !== addr_last)
            abort_run("sdram_addr changed while sdram_req was waiting for sdram_ack");
        if (rst_n && sdram_req && refresh_en)
            abort_run("refresh_en was high while an SDRAM access was under way");
        if (rst_n && sdram_req && !req_last)
            req_count++;
        req_last  = sdram_req;
        addr_last = sdram_addr;
    end

    initial begin : watchdog
        repeat (N_ACCESS * 40 + 100) @(posedge clk);
        abort_run("Timeout: a port never saw its ok flag");
    end

    initial begin : main
        int                  idx;
        int                  reqs_before;
        logic [SDRAM_AW-1:0] a;

        void'($urandom(32'hb7b1));
        rst_n       = 1'b0;
        vblank      = 1'b0;
        downloading = 1'b0;
        loop_rst    = 1'b0;
        rom_cs      = 1'b0;
        rom_addr    = '0;
        ram_cs      = 1'b0;
        ram_addr    = '0;
        ram_rnw     = 1'b1;
        ram_din     = '0;
        ram_wrmask  = 2'b11;
        vram_cs     = 1'b0;
        vram_addr   = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        req_count   = 0;
        req_last    = 1'b0;
        addr_last   = '0;
        conc_done   = 1'b0;

        // One extra word per window for the upper half of 32-bit reads
        for (int i = 0; i <= WIN; i++) begin
            a = ROM_OFFSET + SDRAM_AW'(i);
            u_model.mem[a] = mem_word(a);
            a = GFX_OFFSET + SDRAM_AW'(i);
            u_model.mem[a] = mem_word(a);
            a = SHADOW_BASE + SDRAM_AW'(i);
            u_model.mem[a] = mem_word(a);
            if (i < WIN)
                shadow[i] = mem_word(a);
        end

        repeat (5) @(negedge clk);
        if (sdram_req || rom_ok || ram_ok || vram_ok || gfx_ok || !refresh_en)
            abort_run("Outputs are not at their reset values during reset");
        rst_n = 1'b1;

        read_traffic(SLOT_ROM, N_ROM, 0, WIN - 1);
        read_traffic(SLOT_GFX, N_GFX, 0, WIN - 1);

        // Writes seen back through RAM and through VRAM
        for (int i = 0; i < N_RAM; i++) begin
            idx = $urandom_range(WIN - 1, 0);
            ram_round(idx);
            pulse_loop_rst();
            read_check(SLOT_VRAM, 20'(idx));
        end

        // Cache hit answers on the next cycle without the controller
        read_check(SLOT_ROM, 20'h155);
        reqs_before = req_count;
        @(negedge clk);
        drive_port(SLOT_ROM, 1'b1, 20'h155, 1'b1, 16'h0000, 2'b11);
        @(negedge clk);
        if (!rom_ok)
            abort_run("Cache hit did not raise rom_ok on the cycle after rom_cs");
        check_half("rom cache hit", rom_data, ref_half(ROM_OFFSET + 22'h155));
        drive_port(SLOT_ROM, 1'b0, 20'h155, 1'b1, 16'h0000, 2'b11);
        if (req_count != reqs_before)
            abort_run("Cache hit issued an SDRAM request");
        pulse_loop_rst();
        read_check(SLOT_ROM, 20'h155);
        if (req_count != reqs_before + 1)
            abort_run("ROM read after loop_rst did not go to SDRAM");

        // All ports at once, RAM and VRAM on separate halves of the window
        fork
            begin
                fork
                    read_traffic(SLOT_ROM, N_CONC, 0, WIN - 1);
                    read_traffic(SLOT_GFX, N_CONC, 0, WIN - 1);
                    read_traffic(SLOT_VRAM, N_CONC, WIN / 2, WIN - 1);
                    ram_traffic(N_CONC, 0, WIN / 2 - 1);
                join
                conc_done = 1'b1;
            end
            while (!conc_done) begin
                @(negedge clk);
                if ($urandom_range(15, 0) == 0)
                    vblank = !vblank;
            end
        join
        vblank = 1'b0;

        // Requests wait in their fronts until downloading drops
        pulse_loop_rst();
        @(negedge clk);
        downloading = 1'b1;
        reqs_before = req_count;
        fork
            read_check(SLOT_ROM, 20'h2A0);
            read_check(SLOT_GFX, 20'h1F0);
            read_check(SLOT_VRAM, 20'h300);
            read_check(SLOT_RAM, 20'(RAM_WIN + 17'h040));
            begin
                repeat (30) @(negedge clk);
                if (req_count != reqs_before)
                    abort_run("An SDRAM request rose while downloading was high");
                downloading = 1'b0;
            end
        join

        $display("** PASS **");
        $finish;
    end

endmodule

// File: verif/sdram_model.sv
// Behavioral SDRAM controller: random ack and data_rdy delays over a word array
`timescale 1ns/1ns

module sdram_model import sdram_mux_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_rnw,
    input  logic [1:0]          sdram_wrmask,
    input  logic [15:0]         data_write,
    output logic                sdram_ack,
    output logic                data_rdy,
    output sdram_word_u         data_read
);

    logic [15:0] mem [0:(1 << SDRAM_AW) - 1];  // Contents loaded by the testbench

    initial begin : serve
        int unsigned         ack_wait;
        int unsigned         data_wait;
        logic [SDRAM_AW-1:0] a;

        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (rst_n && sdram_req) begin
                ack_wait = $urandom_range(6, 0);
                repeat (ack_wait) @(negedge clk);
                a = sdram_addr;  // Held stable until ack
                if (!sdram_rnw) begin
                    // Byte lanes with a low mask bit are written
                    if (!sdram_wrmask[1])
                        mem[a][15:8] = data_write[15:8];
                    if (!sdram_wrmask[0])
                        mem[a][7:0] = data_write[7:0];
                end
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                data_wait = $urandom_range(4, 1);
                repeat (data_wait - 1) @(negedge clk);
                data_read.half.lo = mem[a];
                data_read.half.hi = mem[a + 1'b1];  // Next word for 32-bit reads
                data_rdy = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

endmodule

// File: verif/tb_clock.sv
// Testbench clock source with a configurable period
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: source/sdram_mux.sv
// SDRAM slot multiplexer top: four client fronts, arbiter and controller issuer
`timescale 1ns/1ns

module sdram_mux import sdram_mux_pkg::*; #(
    parameter logic [SDRAM_AW-1:0] ROM_OFFSET  = 22'h00_0000,
    parameter logic [SDRAM_AW-1:0] RAM_OFFSET  = 22'h3A_8000,
    parameter logic [SDRAM_AW-1:0] VRAM_OFFSET = 22'h3B_0000,
    parameter logic [SDRAM_AW-1:0] GFX_OFFSET  = 22'h0A_8000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vblank,
    input  logic                downloading,
    input  logic                loop_rst,
    // CPU program ROM
    input  logic                rom_cs,
    input  logic [18:0]         rom_addr,
    output logic [15:0]         rom_data,
    output logic                rom_ok,
    // CPU work RAM
    input  logic                ram_cs,
    input  logic [16:0]         ram_addr,
    input  logic                ram_rnw,
    input  logic [15:0]         ram_din,
    input  logic [1:0]          ram_wrmask,
    output logic [15:0]         ram_data,
    output logic                ram_ok,
    // Video RAM reader
    input  logic                vram_cs,
    input  logic [17:0]         vram_addr,
    output logic [15:0]         vram_data,
    output logic                vram_ok,
    // Graphics ROM reader
    input  logic                gfx_cs,
    input  logic [19:0]         gfx_addr,
    output sdram_word_u         gfx_data,
    output logic                gfx_ok,
    // SDRAM controller
    output logic                sdram_req,
    input  logic                sdram_ack,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_rnw,
    output logic [1:0]          sdram_wrmask,
    output logic [15:0]         data_write,
    input  logic                data_rdy,
    input  sdram_word_u         data_read,
    output logic                refresh_en
);

    logic [SLOT_N-1:0] pending;
    logic [SLOT_N-1:0] grant;
    slot_req_t         reqs [SLOT_N];
    sdram_word_u       rom_word;
    sdram_word_u       ram_word;
    sdram_word_u       vram_word;
    logic              cmd_valid;
    slot_req_t         cmd;
    slot_id_t          cmd_slot;
    logic              busy;
    slot_resp_t        resp;

    // 16-bit ports take the word at their own address
    assign rom_data  = rom_word.half.lo;
    assign ram_data  = ram_word.half.lo;
    assign vram_data = vram_word.half.lo;

    slot_front #(.AW(19), .OFFSET(ROM_OFFSET), .WRITABLE(1'b0), .SLOT(SLOT_ROM)) u_rom (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .loop_rst ( loop_rst        ),
        .cs       ( rom_cs          ),
        .addr     ( rom_addr        ),
        .rnw      ( 1'b1            ),
        .din      ( 16'h0000        ),
        .wrmask   ( 2'b11           ),
        .grant    ( grant[SLOT_ROM] ),
        .resp     ( resp            ),
        .pending  ( pending[SLOT_ROM] ),
        .req      ( reqs[SLOT_ROM]  ),
        .dout     ( rom_word        ),
        .ok       ( rom_ok          )
    );

    slot_front #(.AW(17), .OFFSET(RAM_OFFSET), .WRITABLE(1'b1), .SLOT(SLOT_RAM)) u_ram (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .loop_rst ( loop_rst        ),
        .cs       ( ram_cs          ),
        .addr     ( ram_addr        ),
        .rnw      ( ram_rnw         ),
        .din      ( ram_din         ),
        .wrmask   ( ram_wrmask      ),
        .grant    ( grant[SLOT_RAM] ),
        .resp     ( resp            ),
        .pending  ( pending[SLOT_RAM] ),
        .req      ( reqs[SLOT_RAM]  ),
        .dout     ( ram_word        ),
        .ok       ( ram_ok          )
    );

    slot_front #(.AW(18), .OFFSET(VRAM_OFFSET), .WRITABLE(1'b0), .SLOT(SLOT_VRAM)) u_vram (
        .clk      ( clk              ),
        .rst_n    ( rst_n            ),
        .loop_rst ( loop_rst         ),
        .cs       ( vram_cs          ),
        .addr     ( vram_addr        ),
        .rnw      ( 1'b1             ),
        .din      ( 16'h0000         ),
        .wrmask   ( 2'b11            ),
        .grant    ( grant[SLOT_VRAM] ),
        .resp     ( resp             ),
        .pending  ( pending[SLOT_VRAM] ),
        .req      ( reqs[SLOT_VRAM]  ),
        .dout     ( vram_word        ),
        .ok       ( vram_ok          )
    );

    slot_front #(.AW(20), .OFFSET(GFX_OFFSET), .WRITABLE(1'b0), .SLOT(SLOT_GFX)) u_gfx (
        .clk      ( clk             ),
        .rst_n    ( rst_n           ),
        .loop_rst ( loop_rst        ),
        .cs       ( gfx_cs          ),
        .addr     ( gfx_addr        ),
        .rnw      ( 1'b1            ),
        .din      ( 16'h0000        ),
        .wrmask   ( 2'b11           ),
        .grant    ( grant[SLOT_GFX] ),
        .resp     ( resp            ),
        .pending  ( pending[SLOT_GFX] ),
        .req      ( reqs[SLOT_GFX]  ),
        .dout     ( gfx_data        ),
        .ok       ( gfx_ok          )
    );

    slot_arbiter u_arbiter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .vblank      ( vblank      ),
        .downloading ( downloading ),
        .pending     ( pending     ),
        .reqs        ( reqs        ),
        .busy        ( busy        ),
        .grant       ( grant       ),
        .cmd_valid   ( cmd_valid   ),
        .cmd         ( cmd         ),
        .cmd_slot    ( cmd_slot    ),
        .refresh_en  ( refresh_en  )
    );

    sdram_issue u_issue (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .cmd_valid    ( cmd_valid    ),
        .cmd          ( cmd          ),
        .cmd_slot     ( cmd_slot     ),
        .sdram_ack    ( sdram_ack    ),
        .data_rdy     ( data_rdy     ),
        .data_read    ( data_read    ),
        .busy         ( busy         ),
        .resp         ( resp         ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rnw    ( sdram_rnw    ),
        .sdram_wrmask ( sdram_wrmask ),
        .data_write   ( data_write   )
    );

endmodule

// File: source/sdram_issue.sv
// SDRAM issuer: runs the req/ack/data_rdy handshake and returns tagged data
`timescale 1ns/1ns

module sdram_issue import sdram_mux_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  slot_req_t           cmd,
    input  slot_id_t            cmd_slot,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  sdram_word_u         data_read,
    output logic                busy,
    output slot_resp_t          resp,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_rnw,
    output logic [1:0]          sdram_wrmask,
    output logic [15:0]         data_write
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    state_t      state;
    slot_req_t   held;       // Command on the controller pins
    slot_id_t    held_slot;
    logic        resp_valid;
    sdram_word_u resp_data;

    assign busy         = (state != IDLE);
    assign sdram_addr   = held.addr;
    assign sdram_rnw    = held.rnw;
    assign sdram_wrmask = held.wrmask;
    assign data_write   = held.data;

    // held_slot is still valid here, the next command lands a cycle later
    assign resp = '{valid: resp_valid, slot: held_slot, data: resp_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            sdram_req  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        sdram_req <= 1'b1;
                        state     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    // data_rdy closes writes too
                    if (data_rdy) begin
                        resp_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            held      <= cmd;
            held_slot <= cmd_slot;
        end
        if (state == WAIT_DATA && data_rdy) begin
            resp_data <= data_read;
        end
    end

    // Controller sees a steady request until it acknowledges
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr));

    // Arbiter must wait for the previous access to finish
    a_cmd_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |-> !busy);

endmodule

// File: source/slot_arbiter.sv
// Slot arbiter: fixed priority that reverses in vblank, one command at a time
`timescale 1ns/1ns

module slot_arbiter import sdram_mux_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              vblank,
    input  logic              downloading,
    input  logic [SLOT_N-1:0] pending,
    input  slot_req_t         reqs [SLOT_N],
    input  logic              busy,
    output logic [SLOT_N-1:0] grant,
    output logic              cmd_valid,
    output slot_req_t         cmd,
    output slot_id_t          cmd_slot,
    output logic              refresh_en
);

    // Active display order, vblank scans it from the other end
    localparam slot_id_t PRIO [SLOT_N] = '{SLOT_VRAM, SLOT_GFX, SLOT_ROM, SLOT_RAM};

    logic     open;
    slot_id_t winner;

    // cmd_valid covers the cycle before busy rises
    assign open       = !busy && !cmd_valid && !downloading;
    assign refresh_en = !busy && !cmd_valid && (pending == '0);

    always_comb begin
        slot_id_t idx;
        logic     found;

        grant  = '0;
        winner = SLOT_ROM;
        found  = 1'b0;
        for (int i = 0; i < SLOT_N; i++) begin
            idx = vblank ? PRIO[SLOT_N-1-i] : PRIO[i];
            if (open && !found && pending[idx]) begin
                grant[idx] = 1'b1;
                winner     = idx;
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= |grant;  // Single pulse per grant
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            cmd      <= reqs[winner];
            cmd_slot <= winner;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

endmodule

// File: source/slot_front.sv
// Client port front: adds the base offset, captures requests, caches one read word
`timescale 1ns/1ns

module slot_front import sdram_mux_pkg::*; #(
    parameter int                  AW       = 16,
    parameter logic [SDRAM_AW-1:0] OFFSET   = '0,
    parameter bit                  WRITABLE = 1'b0,
    parameter slot_id_t            SLOT     = SLOT_ROM
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          loop_rst,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  logic          rnw,
    input  logic [15:0]   din,
    input  logic [1:0]    wrmask,
    input  logic          grant,
    input  slot_resp_t    resp,
    output logic          pending,
    output slot_req_t     req,
    output sdram_word_u   dout,
    output logic          ok
);

    logic [SDRAM_AW-1:0] abs_addr;
    logic [SDRAM_AW-1:0] cache_addr;
    sdram_word_u         cache_data;
    logic                cache_valid;
    logic                inflight;   // Granted, waiting for our tag
    logic                rd;
    logic                hit;
    logic                mine;
    logic                start;

    assign abs_addr = OFFSET + SDRAM_AW'(addr);
    assign rd       = WRITABLE ? rnw : 1'b1;  // Read-only ports never write
    assign hit      = rd && cache_valid && (cache_addr == abs_addr);
    assign mine     = resp.valid && (resp.slot == SLOT) && inflight;
    // Writes always miss, ok high means the client is still moving on
    assign start    = cs && !hit && !pending && !inflight && !ok;
    assign dout     = cache_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= 1'b0;
            inflight    <= 1'b0;
            cache_valid <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= cs && (hit || mine);  // A write answer gives a single pulse

            if (start) begin
                pending <= 1'b1;
            end else if (grant) begin
                pending <= 1'b0;
            end

            if (grant) begin
                inflight <= 1'b1;
            end else if (mine) begin
                inflight <= 1'b0;
            end

            // A write leaves the cached word unknown
            if (loop_rst || (start && !rd)) begin
                cache_valid <= 1'b0;
            end else if (mine && req.rnw) begin
                cache_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req.addr   <= abs_addr;
            req.rnw    <= rd;
            req.wrmask <= WRITABLE ? wrmask : 2'b11;
            req.data   <= din;
        end
        if (mine && req.rnw) begin
            cache_addr <= req.addr;
            cache_data <= resp.data;
        end
    end

    // ok only closes an access with nothing of it left under way
    a_ok_ends_access: assert property (@(posedge clk) disable iff (!rst_n)
        ok |-> !pending && !inflight);

    // Arbiter only grants a front that is waiting
    a_grant_pending: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> pending && !inflight);

endmodule

// File: source/sdram_mux_pkg.sv
// SDRAM slot multiplexer shared types: widths, port tags, request and response words
package sdram_mux_pkg;

    localparam int SDRAM_AW = 22;  // SDRAM word address width
    localparam int SLOT_N   = 4;   // Client ports

    typedef logic [1:0] slot_id_t;

    localparam slot_id_t SLOT_ROM  = 2'd0;
    localparam slot_id_t SLOT_RAM  = 2'd1;
    localparam slot_id_t SLOT_VRAM = 2'd2;
    localparam slot_id_t SLOT_GFX  = 2'd3;

    // One access as it leaves a front
    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;    // Absolute word address
        logic                rnw;
        logic [1:0]          wrmask;  // Active low, one bit per byte
        logic [15:0]         data;
    } slot_req_t;

    // Lo is the word at the address, hi the one after it
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } half_pair_t;

    // Controller read word, whole for GFX or split for 16-bit ports
    typedef union packed {
        logic [31:0] word;
        half_pair_t  half;
    } sdram_word_u;

    // Completed access, broadcast to every front
    typedef struct packed {
        logic        valid;
        slot_id_t    slot;
        sdram_word_u data;
    } slot_resp_t;

endpackage
